// File: Makefile
# Verilator build and run of the divide unit testbench.

VERILATOR ?= verilator
TOP ?= div_unit_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
verilog/div_pkg.sv
verilog/div_control.sv
verilog/div_step_counter.sv
verilog/div_operand_prep.sv
verilog/div_iter_datapath.sv
verilog/div_result_pack.sv
verilog/div_unit_top.sv
verification/tb_clock_gen.sv
verification/div_unit_tb.sv

// File: verification/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

   localparam int n_random = 40;
   localparam int n_corner = 12;
   localparam int max_stall = 8;
   localparam int total_ops = 4 * n_random + n_corner;
   // each op takes N+1 steps, about six handshake cycles and its stall
   localparam int cycle_limit = total_ops * (66 + 6 + max_stall) + 100;

   logic clk;
   logic reset;
   logic req_valid;
   logic req_ready;
   div_pkg::div_req_t req;
   logic resp_valid;
   logic resp_ready;
   div_pkg::div_resp_t resp;

   logic [31:0] lfsr;
   div_pkg::div_resp_t exp_q[$];
   int cycle_count = 0;
   int check_count = 0;
   int error_count = 0;
   int test_count = 0;
   int test_errors = 0;
   int test_ops = 0;

   tb_clock_gen u_clock
   (
      .clk(clk),
      .reset(reset)
   );

   div_unit_top dut
   (
      .clk(clk),
      .reset(reset),
      .req_valid(req_valid),
      .req_ready(req_ready),
      .req(req),
      .resp_valid(resp_valid),
      .resp_ready(resp_ready),
      .resp(resp)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1.
   endfunction

   task automatic rand_bits(input int n, output logic [63:0] v);
      int k;
      begin
         v = 64'h0;
         for (k = 0; k < n; k = k + 1)
         begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
         end
      end
   endtask

   // RISC-V divide rules, word operands widened to 64 bits first
   function automatic logic [63:0] model_result(input div_pkg::div_op_e op, input logic is_word,
                                                input logic [63:0] a, input logic [63:0] b);
      logic signed_op;
      logic rem_op;
      logic [63:0] x;
      logic [63:0] y;
      logic [63:0] ux;
      logic [63:0] uy;
      logic [63:0] q;
      logic [63:0] r;
      logic [63:0] res;
      begin
         signed_op = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
         rem_op = (op == div_pkg::op_rem) || (op == div_pkg::op_remu);
         x = is_word ? {signed_op ? {32{a[31]}} : 32'h0, a[31:0]} : a;
         y = is_word ? {signed_op ? {32{b[31]}} : 32'h0, b[31:0]} : b;
         if (y == 64'h0)
         begin
            q = '1;
            r = x;
         end
         else if (signed_op && (x == 64'h8000_0000_0000_0000) && (y == '1))
         begin
            q = x;                          // signed overflow.
            r = 64'h0;
         end
         else
         begin
            ux = (signed_op && x[63]) ? -x : x;
            uy = (signed_op && y[63]) ? -y : y;
            q = ux / uy;
            r = ux % uy;
            q = (signed_op && (x[63] ^ y[63])) ? -q : q;
            r = (signed_op && x[63]) ? -r : r;
         end
         res = rem_op ? r : q;
         return is_word ? {{32{res[31]}}, res[31:0]} : res;
      end
   endfunction

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      begin
         check_count = check_count + 1;
         if (got !== exp)
         begin
            $display("ERR %s got %h expected %h", name, got, exp);
            error_count = error_count + 1;
            test_errors = test_errors + 1;
         end
      end
   endtask

   task automatic end_test(input string name);
      begin
         $display("test %s: %0d ops, %0d errors", name, test_ops, test_errors);
         test_count = test_count + 1;
         test_ops = 0;
         test_errors = 0;
      end
   endtask

   // biased toward zero, most negative, minus one and small values
   task automatic pick_operand(input logic is_word, output logic [63:0] v);
      logic [63:0] sel;
      logic [63:0] raw;
      logic [63:0] pick;
      begin
         rand_bits(3, sel);
         rand_bits(64, raw);
         case (sel[2:0])
            3'd0: pick = 64'h0;
            3'd1: pick = is_word ? 64'h8000_0000 : 64'h8000_0000_0000_0000;
            3'd2: pick = '1;
            3'd3: pick = {56'h0, raw[7:0]};
            3'd4: pick = ~{56'h0, raw[7:0]};
            default: pick = raw;
         endcase
         v = is_word ? {raw[63:32], pick[31:0]} : pick;    // junk in the upper half.
      end
   endtask

   task automatic run_op(input div_pkg::div_op_e op, input logic is_word,
                         input logic [63:0] a, input logic [63:0] b, input int stall);
      div_pkg::div_req_t r;
      div_pkg::div_resp_t e;
      logic [63:0] tags;
      int lat;
      int k;
      begin
         rand_bits(13, tags);
         r.op = op;
         r.is_word = is_word;
         r.src_a = a;
         r.src_b = b;
         r.rob_tag = tags[12:7];
         r.prf_tag = tags[6:0];
         e.result = model_result(op, is_word, a, b);
         e.rob_tag = r.rob_tag;
         e.prf_tag = r.prf_tag;
         exp_q.push_back(e);
         @(posedge clk);
         req <= r;
         req_valid <= 1'b1;
         @(negedge clk);
         while (!req_ready)
         begin
            @(negedge clk);
         end
         @(posedge clk);                    // transfer edge.
         req_valid <= 1'b0;
         lat = 0;
         @(negedge clk);
         while (!resp_valid)
         begin
            check_value("req_ready", 64'(req_ready), 64'h0);
            lat = lat + 1;
            @(negedge clk);
         end
         check_value("latency", 64'(lat), is_word ? 64'd33 : 64'd65);
         check_value("req_ready", 64'(req_ready), 64'h0);
         e = exp_q.pop_front();
         check_value("resp.result", resp.result, e.result);
         check_value("resp.rob_tag", 64'(resp.rob_tag), 64'(e.rob_tag));
         check_value("resp.prf_tag", 64'(resp.prf_tag), 64'(e.prf_tag));
         // a pending request waits while the writeback is stalled
         for (k = 0; k < stall; k = k + 1)
         begin
            @(posedge clk);
            req_valid <= 1'b1;
            @(negedge clk);
            check_value("req_ready", 64'(req_ready), 64'h0);
            check_value("resp_valid", 64'(resp_valid), 64'h1);
            check_value("resp.result", resp.result, e.result);
            check_value("resp.rob_tag", 64'(resp.rob_tag), 64'(e.rob_tag));
            check_value("resp.prf_tag", 64'(resp.prf_tag), 64'(e.prf_tag));
         end
         @(posedge clk);
         resp_ready <= 1'b1;
         req_valid <= 1'b0;
         @(posedge clk);                    // response leaves.
         resp_ready <= 1'b0;
         @(negedge clk);
         check_value("resp_valid", 64'(resp_valid), 64'h0);
         check_value("req_ready", 64'(req_ready), 64'h1);
         test_ops = test_ops + 1;
      end
   endtask

   task automatic run_batch(input int kind);
      logic [63:0] bits;
      logic [63:0] a;
      logic [63:0] b;
      logic is_word;
      div_pkg::div_op_e op;
      int i;
      int stall;
      begin
         for (i = 0; i < n_random; i = i + 1)
         begin
            rand_bits(6, bits);
            is_word = (kind == 2) || ((kind == 3) && bits[2]);
            stall = (kind == 3) ? int'(bits[5:3]) + 1 : 0;
            case (kind)
               0: op = bits[0] ? div_pkg::op_remu : div_pkg::op_divu;
               1: op = bits[0] ? div_pkg::op_rem : div_pkg::op_div;
               default: op = div_pkg::div_op_e'(bits[1:0]);
            endcase
            pick_operand(is_word, a);
            pick_operand(is_word, b);
            run_op(op, is_word, a, b, stall);
         end
      end
   endtask

   task automatic run_corners;
      logic [63:0] junk;
      int k;
      begin
         rand_bits(64, junk);
         for (k = 0; k < 4; k = k + 1)
         begin
            run_op(div_pkg::div_op_e'(k), 1'b0, junk, 64'h0, 0);
            run_op(div_pkg::div_op_e'(k), 1'b1, junk, {junk[63:32], 32'h0}, 0);
         end
         run_op(div_pkg::op_div, 1'b0, 64'h8000_0000_0000_0000, '1, 0);
         run_op(div_pkg::op_rem, 1'b0, 64'h8000_0000_0000_0000, '1, 0);
         run_op(div_pkg::op_div, 1'b1, {junk[31:0], 32'h8000_0000}, {junk[63:32], 32'hffff_ffff}, 0);
         run_op(div_pkg::op_rem, 1'b1, {junk[31:0], 32'h8000_0000}, {junk[63:32], 32'hffff_ffff}, 0);
      end
   endtask

   initial
   begin
      cycle_count = 0;
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      req_valid = 1'b0;
      resp_ready = 1'b0;
      req = '0;
      lfsr = 32'h4d35;
      @(negedge clk);
      while (reset)
      begin
         @(negedge clk);
      end
      check_value("req_ready", 64'(req_ready), 64'h1);
      check_value("resp_valid", 64'(resp_valid), 64'h0);
      end_test("reset");
      run_batch(0);
      end_test("unsigned full width");
      run_batch(1);
      end_test("signed full width");
      run_corners();
      end_test("zero divisor and overflow");
      run_batch(2);
      end_test("word variants");
      run_batch(3);
      end_test("writeback stall");
      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #2 clk = ~clk;                     // 4 ns period.
      end
   end

   initial
   begin
      reset = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

// File: verilog/div_control.sv
`timescale 1ns/1ps

module div_control
(
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic counter_last,
   input logic resp_ready,
   output logic req_ready,
   output logic load,
   output logic step_en,
   output logic pack_en,
   output logic resp_valid
);

   div_pkg::div_state_e r_state;
   div_pkg::div_state_e n_state;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= div_pkg::st_idle;
      end
      else
      begin
         r_state <= n_state;
      end
   end

   always_comb
   begin
      req_ready = (r_state == div_pkg::st_idle);
      load = req_ready && req_valid;        // issue handshake.
      step_en = (r_state == div_pkg::st_divide);
      pack_en = (r_state == div_pkg::st_pack);
      resp_valid = (r_state == div_pkg::st_wb);
   end

   always_comb
   begin
      n_state = r_state;
      unique case (r_state)
         div_pkg::st_idle:
         begin
            if (req_valid)
            begin
               n_state = div_pkg::st_divide;
            end
         end
         div_pkg::st_divide:
         begin
            if (counter_last)
            begin
               n_state = div_pkg::st_pack;   // final quotient bit this edge.
            end
         end
         div_pkg::st_pack:
         begin
            n_state = div_pkg::st_wb;
         end
         div_pkg::st_wb:
         begin
            if (resp_ready)
            begin
               n_state = div_pkg::st_idle;
            end
         end
         default:
         begin
            n_state = div_pkg::st_idle;
         end
      endcase
   end

   a_no_ready_with_valid: assert property (@(posedge clk) disable iff (reset)
      !(resp_valid && req_ready));

   // the counter's last flag has to stop the iteration on the next edge
   a_stop_after_last: assert property (@(posedge clk) disable iff (reset)
      (step_en && counter_last) |=> !step_en);

endmodule

// File: verilog/div_iter_datapath.sv
`timescale 1ns/1ps

module div_iter_datapath
(
   input logic clk,
   input logic reset,
   input logic load,
   input logic step_en,
   input logic [div_pkg::xlen-1:0] mag_a,
   input logic [div_pkg::xlen-1:0] mag_b,
   output logic [div_pkg::xlen-1:0] quotient,
   output logic [div_pkg::xlen-1:0] remainder_hi
);

   localparam int w2 = 2 * div_pkg::xlen;

   logic [w2-1:0] r_rem;
   logic [div_pkg::xlen-1:0] r_divisor;
   logic [div_pkg::xlen-1:0] r_quot;
   logic [w2-1:0] shifted;
   logic [div_pkg::xlen-1:0] shifted_hi;
   logic take;

   // divisor lives in the upper half, so only the top half is compared
   always_comb
   begin
      shifted = {r_rem[w2-2:0], 1'b0};
      shifted_hi = shifted[w2-1:div_pkg::xlen];
      take = (shifted_hi >= r_divisor);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_rem <= '0;
         r_divisor <= '0;
         r_quot <= '0;
      end
      else if (load)
      begin
         r_rem <= {{div_pkg::xlen{1'b0}}, mag_a};
         r_divisor <= mag_b;
         r_quot <= '0;
      end
      else if (step_en)
      begin
         if (take)
         begin
            r_rem <= {shifted_hi - r_divisor, shifted[div_pkg::xlen-1:0]};
         end
         else
         begin
            r_rem <= shifted;               // restore.
         end
         r_quot <= {r_quot[div_pkg::xlen-2:0], take};
      end
   end

   assign quotient = r_quot;
   assign remainder_hi = r_rem[w2-1:div_pkg::xlen];

endmodule

// File: verilog/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep
(
   input logic clk,
   input logic reset,
   input logic load,
   input div_pkg::div_req_t req,
   output logic [div_pkg::xlen-1:0] mag_a,
   output logic [div_pkg::xlen-1:0] mag_b,
   output div_pkg::div_ctx_t ctx
);

   localparam int pad = div_pkg::xlen - div_pkg::word_len;

   logic is_signed;
   logic is_rem;
   logic sign_a;
   logic sign_b;
   logic [div_pkg::word_len-1:0] low_a;
   logic [div_pkg::word_len-1:0] low_b;
   logic [div_pkg::word_len-1:0] abs_a_w;
   logic [div_pkg::word_len-1:0] abs_b_w;
   logic [div_pkg::xlen-1:0] abs_a;
   logic [div_pkg::xlen-1:0] abs_b;
   div_pkg::div_ctx_t n_ctx;

   always_comb
   begin
      is_signed = (req.op == div_pkg::op_div) || (req.op == div_pkg::op_rem);
      is_rem = (req.op == div_pkg::op_rem) || (req.op == div_pkg::op_remu);
      low_a = req.src_a[div_pkg::word_len-1:0];
      low_b = req.src_b[div_pkg::word_len-1:0];

      sign_a = is_signed && (req.is_word ? low_a[div_pkg::word_len-1]
                                         : req.src_a[div_pkg::xlen-1]);
      sign_b = is_signed && (req.is_word ? low_b[div_pkg::word_len-1]
                                         : req.src_b[div_pkg::xlen-1]);

      abs_a = sign_a ? (~req.src_a + 1'b1) : req.src_a;
      abs_b = sign_b ? (~req.src_b + 1'b1) : req.src_b;
      abs_a_w = sign_a ? (~low_a + 1'b1) : low_a;
      abs_b_w = sign_b ? (~low_b + 1'b1) : low_b;

      // word dividend sits in the top half so 32 steps drain it
      if (req.is_word)
      begin
         mag_a = {abs_a_w, {pad{1'b0}}};
         mag_b = {{pad{1'b0}}, abs_b_w};
      end
      else
      begin
         mag_a = abs_a;
         mag_b = abs_b;
      end

      n_ctx.quot_neg = sign_a ^ sign_b;
      n_ctx.rem_neg = sign_a;               // remainder follows dividend.
      n_ctx.is_rem = is_rem;
      n_ctx.is_word = req.is_word;
      n_ctx.div_zero = req.is_word ? (low_b == '0) : (req.src_b == '0);
      n_ctx.dividend = req.is_word ? {{pad{low_a[div_pkg::word_len-1]}}, low_a}
                                   : req.src_a;
      n_ctx.rob_tag = req.rob_tag;
      n_ctx.prf_tag = req.prf_tag;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ctx <= '0;
      end
      else if (load)
      begin
         ctx <= n_ctx;
      end
   end

endmodule

// File: verilog/div_pkg.sv
package div_pkg;

   localparam int xlen = 64;
   localparam int word_len = 32;
   localparam int lg_rob_entries = 6;
   localparam int lg_prf_entries = 7;
   localparam int lg_steps = 6;

   typedef enum logic [1:0]
   {
      op_div = 2'd0,
      op_divu = 2'd1,
      op_rem = 2'd2,
      op_remu = 2'd3
   } div_op_e;

   typedef enum logic [1:0]
   {
      st_idle = 2'd0,
      st_divide = 2'd1,
      st_pack = 2'd2,
      st_wb = 2'd3
   } div_state_e;

   typedef struct packed
   {
      div_op_e op;
      logic is_word;                       // low 32 bits only.
      logic [xlen-1:0] src_a;              // dividend.
      logic [xlen-1:0] src_b;              // divisor.
      logic [lg_rob_entries-1:0] rob_tag;
      logic [lg_prf_entries-1:0] prf_tag;
   } div_req_t;

   typedef struct packed
   {
      logic [xlen-1:0] result;
      logic [lg_rob_entries-1:0] rob_tag;
      logic [lg_prf_entries-1:0] prf_tag;
   } div_resp_t;

   // captured on accept, consumed by the result stage
   typedef struct packed
   {
      logic quot_neg;
      logic rem_neg;
      logic is_rem;
      logic is_word;
      logic div_zero;
      logic [xlen-1:0] dividend;           // sign-extended for word ops.
      logic [lg_rob_entries-1:0] rob_tag;
      logic [lg_prf_entries-1:0] prf_tag;
   } div_ctx_t;

endpackage

// File: verilog/div_result_pack.sv
`timescale 1ns/1ps

module div_result_pack
(
   input logic clk,
   input logic reset,
   input logic pack_en,
   input div_pkg::div_ctx_t ctx,
   input logic [div_pkg::xlen-1:0] quotient,
   input logic [div_pkg::xlen-1:0] remainder_hi,
   output div_pkg::div_resp_t resp
);

   localparam int pad = div_pkg::xlen - div_pkg::word_len;

   logic [div_pkg::xlen-1:0] quot_fix;
   logic [div_pkg::xlen-1:0] rem_fix;
   logic [div_pkg::xlen-1:0] sel;
   logic [div_pkg::xlen-1:0] result;

   always_comb
   begin
      quot_fix = ctx.quot_neg ? (~quotient + 1'b1) : quotient;
      rem_fix = ctx.rem_neg ? (~remainder_hi + 1'b1) : remainder_hi;
      sel = ctx.is_rem ? rem_fix : quot_fix;

      // x / 0 gives all ones, x % 0 gives x
      if (ctx.div_zero)
      begin
         sel = ctx.is_rem ? ctx.dividend : '1;
      end

      if (ctx.is_word)
      begin
         result = {{pad{sel[div_pkg::word_len-1]}}, sel[div_pkg::word_len-1:0]};
      end
      else
      begin
         result = sel;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         resp <= '0;
      end
      else if (pack_en)
      begin
         resp.result <= result;
         resp.rob_tag <= ctx.rob_tag;
         resp.prf_tag <= ctx.prf_tag;
      end
   end

   a_resp_stable: assert property (@(posedge clk) disable iff (reset)
      !pack_en |=> $stable(resp));

endmodule

// File: verilog/div_step_counter.sv
`timescale 1ns/1ps

module div_step_counter
(
   input logic clk,
   input logic reset,
   input logic load,
   input logic is_word,
   input logic step_en,
   output logic counter_last
);

   logic [div_pkg::lg_steps-1:0] r_count;
   logic r_last_taken;

   assign counter_last = (r_count == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_count <= '0;
         r_last_taken <= 1'b0;
      end
      else if (load)
      begin
         r_count <= is_word ? div_pkg::lg_steps'(div_pkg::word_len - 1)
                            : div_pkg::lg_steps'(div_pkg::xlen - 1);
         r_last_taken <= 1'b0;
      end
      else if (step_en)
      begin
         if (counter_last)
         begin
            r_last_taken <= 1'b1;           // hold at zero.
         end
         else
         begin
            r_count <= r_count - 1'b1;
         end
      end
   end

   a_no_extra_step: assert property (@(posedge clk) disable iff (reset)
      !(step_en && counter_last && r_last_taken));

endmodule

// File: verilog/div_unit_top.sv
`timescale 1ns/1ps

module div_unit_top
(
   input logic clk,
   input logic reset,
   input logic req_valid,
   output logic req_ready,
   input div_pkg::div_req_t req,
   output logic resp_valid,
   input logic resp_ready,
   output div_pkg::div_resp_t resp
);

   logic load;
   logic step_en;
   logic pack_en;
   logic counter_last;
   logic [div_pkg::xlen-1:0] mag_a;
   logic [div_pkg::xlen-1:0] mag_b;
   logic [div_pkg::xlen-1:0] quotient;
   logic [div_pkg::xlen-1:0] remainder_hi;
   div_pkg::div_ctx_t ctx;

   div_control u_control
   (
      .clk(clk),
      .reset(reset),
      .req_valid(req_valid),
      .counter_last(counter_last),
      .resp_ready(resp_ready),
      .req_ready(req_ready),
      .load(load),
      .step_en(step_en),
      .pack_en(pack_en),
      .resp_valid(resp_valid)
   );

   div_step_counter u_counter
   (
      .clk(clk),
      .reset(reset),
      .load(load),
      .is_word(req.is_word),
      .step_en(step_en),
      .counter_last(counter_last)
   );

   div_operand_prep u_prep
   (
      .clk(clk),
      .reset(reset),
      .load(load),
      .req(req),
      .mag_a(mag_a),
      .mag_b(mag_b),
      .ctx(ctx)
   );

   div_iter_datapath u_datapath
   (
      .clk(clk),
      .reset(reset),
      .load(load),
      .step_en(step_en),
      .mag_a(mag_a),
      .mag_b(mag_b),
      .quotient(quotient),
      .remainder_hi(remainder_hi)
   );

   div_result_pack u_pack
   (
      .clk(clk),
      .reset(reset),
      .pack_en(pack_en),
      .ctx(ctx),
      .quotient(quotient),
      .remainder_hi(remainder_hi),
      .resp(resp)
   );

endmodule
